// File: verilog/xfcp_pkg.sv
/*
 * XFCP endpoint shared definitions
 * Stream and Wishbone widths, port count, opcodes and FSM states
 */
package xfcp_pkg;

    localparam int XFCP_DATA_W    = 8;
    localparam int WB_DATA_W      = 32;
    localparam int WB_ADDR_W      = 8;
    localparam int BYTES_PER_WORD = WB_DATA_W / XFCP_DATA_W;
    localparam int NUM_PORTS      = 4;

    typedef logic [XFCP_DATA_W-1:0]       xfcp_byte_t;
    typedef logic [WB_DATA_W-1:0]         wb_word_t;
    typedef logic [WB_ADDR_W-1:0]         wb_addr_t;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // Response opcode is always request + 1
    typedef enum logic [7:0] {
        OP_READ_REQ   = 8'h10,
        OP_READ_RESP  = 8'h11,
        OP_WRITE_REQ  = 8'h12,
        OP_WRITE_RESP = 8'h13
    } xfcp_op_e;

    typedef enum logic [2:0] {
        ROUTE_IDLE,
        ROUTE_DOWN,
        ROUTE_WAIT,
        ROUTE_TAG,
        ROUTE_UP,
        ROUTE_DROP
    } router_state_e;

    typedef enum logic [2:0] {
        M_OP,
        M_ADDR,
        M_COUNT,
        M_WDATA,
        M_WB,
        M_HDR,
        M_RDATA,
        M_DRAIN
    } master_state_e;

endpackage

// File: verilog/wb_ram.sv
/*
 * Wishbone single-port RAM
 * Whole-word writes, registered read data and a one-cycle acknowledge
 */
`timescale 1ns/1ns

module wb_ram import xfcp_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  wb_addr_t adr_i,
    input  wb_word_t dat_i,
    input  logic     we_i,
    input  logic     stb_i,
    input  logic     cyc_i,
    output wb_word_t dat_o,
    output logic     ack_o
);

    wb_word_t mem [2**WB_ADDR_W];
    logic     req;

    // New request only when no ack is outstanding
    assign req = stb_i && cyc_i && !ack_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

endmodule

// File: verilog/xfcp_wb_master.sv
/*
 * XFCP command engine
 * Parses one read or write request from the down stream, runs one
 * Wishbone cycle per word and sends the response on the up stream.
 * Read words are fetched one at a time as the bytes drain out.
 */
`timescale 1ns/1ns

module xfcp_wb_master import xfcp_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  xfcp_byte_t dn_data_i,
    input  logic       dn_valid_i,
    input  logic       dn_last_i,
    output logic       dn_ready_o,

    output xfcp_byte_t up_data_o,
    output logic       up_valid_o,
    output logic       up_last_o,
    input  logic       up_ready_i,

    output wb_addr_t   wb_adr_o,
    output wb_word_t   wb_dat_o,
    output logic       wb_we_o,
    output logic       wb_stb_o,
    output logic       wb_cyc_o,
    input  wb_word_t   wb_dat_i,
    input  logic       wb_ack_i
);

    master_state_e state_q;
    xfcp_op_e      op_q;
    wb_addr_t      addr_q;
    wb_addr_t      cur_q;
    xfcp_byte_t    cnt_q;
    xfcp_byte_t    left_q;
    wb_word_t      word_q;
    logic [1:0]    byte_q;
    logic [1:0]    hdr_q;
    logic          last_q;
    logic          resp_q;
    logic          stb_q;
    logic          we_q;
    logic          dn_beat;
    logic          up_beat;
    logic          is_read;

    assign dn_beat = dn_valid_i && dn_ready_o;
    assign up_beat = up_valid_o && up_ready_i;
    assign is_read = (op_q == OP_READ_REQ);

    assign wb_adr_o = cur_q;
    assign wb_dat_o = word_q;
    assign wb_we_o  = we_q;
    assign wb_stb_o = stb_q;
    assign wb_cyc_o = stb_q;

    always_comb begin
        dn_ready_o = state_q inside {M_OP, M_ADDR, M_COUNT, M_WDATA, M_DRAIN};
        up_valid_o = 1'b0;
        up_last_o  = 1'b0;
        up_data_o  = word_q[7:0];

        case (state_q)
            M_HDR: begin
                up_valid_o = 1'b1;
                case (hdr_q)
                    2'd0:    up_data_o = is_read ? OP_READ_RESP : OP_WRITE_RESP;
                    2'd1:    up_data_o = addr_q;
                    default: up_data_o = cnt_q;
                endcase
                up_last_o = (hdr_q == 2'd2) && (!is_read || cnt_q == '0);
            end
            M_RDATA: begin
                up_valid_o = 1'b1;
                up_last_o  = (byte_q == 2'd3) && (left_q == 8'd1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= M_OP;
            stb_q   <= 1'b0;
            we_q    <= 1'b0;
            resp_q  <= 1'b0;
            last_q  <= 1'b0;
            byte_q  <= '0;
            hdr_q   <= '0;
        end else begin
            case (state_q)
                M_OP: begin
                    if (dn_beat) begin
                        op_q   <= xfcp_op_e'(dn_data_i);
                        resp_q <= 1'b0;
                        if (dn_last_i) begin
                            state_q <= M_OP;
                        end else if (dn_data_i == OP_READ_REQ ||
                                     dn_data_i == OP_WRITE_REQ) begin
                            state_q <= M_ADDR;
                        end else begin
                            state_q <= M_DRAIN;
                        end
                    end
                end
                M_ADDR: begin
                    if (dn_beat) begin
                        addr_q  <= dn_data_i;
                        state_q <= dn_last_i ? M_OP : M_COUNT;
                    end
                end
                M_COUNT: begin
                    if (dn_beat) begin
                        cnt_q  <= dn_data_i;
                        left_q <= dn_data_i;
                        cur_q  <= addr_q;
                        byte_q <= '0;
                        hdr_q  <= '0;
                        last_q <= dn_last_i;
                        resp_q <= 1'b1;
                        we_q   <= !is_read;
                        if (!is_read && dn_data_i != '0 && !dn_last_i) begin
                            state_q <= M_WDATA;
                        end else if (dn_last_i) begin
                            state_q <= M_HDR;
                        end else begin
                            state_q <= M_DRAIN;
                        end
                    end
                end
                M_WDATA: begin
                    if (dn_beat) begin
                        // Least significant byte arrives first
                        word_q <= {dn_data_i, word_q[WB_DATA_W-1:XFCP_DATA_W]};
                        byte_q <= byte_q + 2'd1;
                        last_q <= dn_last_i;
                        if (byte_q == 2'd3) begin
                            stb_q   <= 1'b1;
                            state_q <= M_WB;
                        end else if (dn_last_i) begin
                            // Short packet answered with the words written so far
                            state_q <= M_HDR;
                        end
                    end
                end
                M_WB: begin
                    if (wb_ack_i) begin
                        stb_q <= 1'b0;
                        if (we_q) begin
                            left_q <= left_q - 8'd1;
                            cur_q  <= cur_q + 8'd1;
                            if (last_q) begin
                                state_q <= M_HDR;
                            end else if (left_q == 8'd1) begin
                                state_q <= M_DRAIN;
                            end else begin
                                state_q <= M_WDATA;
                            end
                        end else begin
                            word_q  <= wb_dat_i;
                            byte_q  <= '0;
                            state_q <= M_RDATA;
                        end
                    end
                end
                M_HDR: begin
                    if (up_beat) begin
                        hdr_q <= hdr_q + 2'd1;
                        if (hdr_q == 2'd2) begin
                            if (is_read && cnt_q != '0) begin
                                stb_q   <= 1'b1;
                                state_q <= M_WB;
                            end else begin
                                state_q <= M_OP;
                            end
                        end
                    end
                end
                M_RDATA: begin
                    if (up_beat) begin
                        word_q <= word_q >> XFCP_DATA_W;
                        byte_q <= byte_q + 2'd1;
                        if (byte_q == 2'd3) begin
                            left_q <= left_q - 8'd1;
                            cur_q  <= cur_q + 8'd1;
                            // Next read only once the host took the last byte
                            if (left_q == 8'd1) begin
                                state_q <= M_OP;
                            end else begin
                                stb_q   <= 1'b1;
                                state_q <= M_WB;
                            end
                        end
                    end
                end
                M_DRAIN: begin
                    if (dn_beat && dn_last_i) begin
                        state_q <= resp_q ? M_HDR : M_OP;
                    end
                end
                default: begin
                    state_q <= M_OP;
                end
            endcase
        end
    end

endmodule

// File: verilog/xfcp_router.sv
/*
 * XFCP 1-to-N router
 * Strips the port byte from a host request and forwards the rest to the
 * selected engine, then returns the engine response with the port byte
 * in front. One packet in flight at a time.
 */
`timescale 1ns/1ns

module xfcp_router import xfcp_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    input  xfcp_byte_t                   host_in_data_i,
    input  logic                         host_in_valid_i,
    input  logic                         host_in_last_i,
    output logic                         host_in_ready_o,

    output xfcp_byte_t                   host_out_data_o,
    output logic                         host_out_valid_o,
    output logic                         host_out_last_o,
    input  logic                         host_out_ready_i,

    output xfcp_byte_t [NUM_PORTS-1:0]   dn_data_o,
    output logic       [NUM_PORTS-1:0]   dn_valid_o,
    output logic       [NUM_PORTS-1:0]   dn_last_o,
    input  logic       [NUM_PORTS-1:0]   dn_ready_i,

    input  xfcp_byte_t [NUM_PORTS-1:0]   up_data_i,
    input  logic       [NUM_PORTS-1:0]   up_valid_i,
    input  logic       [NUM_PORTS-1:0]   up_last_i,
    output logic       [NUM_PORTS-1:0]   up_ready_o
);

    router_state_e state_q;
    port_idx_t     port_q;
    logic          op_ok_q;
    logic [1:0]    cnt_q;
    logic          dn_beat;
    logic          up_beat;

    assign dn_beat = host_in_valid_i && host_in_ready_o;
    assign up_beat = host_out_valid_o && host_out_ready_i;

    always_comb begin
        host_in_ready_o  = 1'b0;
        host_out_valid_o = 1'b0;
        host_out_last_o  = 1'b0;
        host_out_data_o  = up_data_i[port_q];
        dn_valid_o       = '0;
        up_ready_o       = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            dn_data_o[i] = host_in_data_i;
            dn_last_o[i] = host_in_last_i;
        end

        case (state_q)
            ROUTE_IDLE, ROUTE_DROP: begin
                host_in_ready_o = 1'b1;
            end
            ROUTE_DOWN: begin
                host_in_ready_o    = dn_ready_i[port_q];
                dn_valid_o[port_q] = host_in_valid_i;
            end
            ROUTE_TAG: begin
                host_out_valid_o = 1'b1;
                host_out_data_o  = xfcp_byte_t'(port_q);
            end
            ROUTE_UP: begin
                host_out_valid_o   = up_valid_i[port_q];
                host_out_last_o    = up_last_i[port_q];
                up_ready_o[port_q] = host_out_ready_i;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ROUTE_IDLE;
            port_q  <= '0;
            op_ok_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ROUTE_IDLE: begin
                    if (dn_beat) begin
                        port_q  <= port_idx_t'(host_in_data_i);
                        op_ok_q <= 1'b0;
                        cnt_q   <= '0;
                        if (host_in_last_i) begin
                            state_q <= ROUTE_IDLE;
                        end else if (host_in_data_i >= NUM_PORTS) begin
                            state_q <= ROUTE_DROP;
                        end else begin
                            state_q <= ROUTE_DOWN;
                        end
                    end
                end
                ROUTE_DOWN: begin
                    if (dn_beat) begin
                        // First forwarded byte is the opcode
                        if (cnt_q == 2'd0) begin
                            op_ok_q <= (host_in_data_i == OP_READ_REQ) ||
                                       (host_in_data_i == OP_WRITE_REQ);
                        end
                        if (cnt_q != 2'd2) begin
                            cnt_q <= cnt_q + 2'd1;
                        end
                        // Engine answers only a known opcode with a full header
                        if (host_in_last_i) begin
                            state_q <= (op_ok_q && cnt_q == 2'd2) ? ROUTE_WAIT : ROUTE_IDLE;
                        end
                    end
                end
                ROUTE_WAIT: begin
                    if (up_valid_i[port_q]) begin
                        state_q <= ROUTE_TAG;
                    end
                end
                ROUTE_TAG: begin
                    if (up_beat) begin
                        state_q <= ROUTE_UP;
                    end
                end
                ROUTE_UP: begin
                    if (up_beat && host_out_last_o) begin
                        state_q <= ROUTE_IDLE;
                    end
                end
                ROUTE_DROP: begin
                    if (dn_beat && host_in_last_i) begin
                        state_q <= ROUTE_IDLE;
                    end
                end
                default: begin
                    state_q <= ROUTE_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/xfcp_core.sv
/*
 * XFCP control endpoint top level
 * One host byte stream routed to four command engines, each with its
 * own Wishbone RAM
 */
`timescale 1ns/1ns

module xfcp_core import xfcp_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  xfcp_byte_t host_in_data_i,
    input  logic       host_in_valid_i,
    input  logic       host_in_last_i,
    output logic       host_in_ready_o,

    output xfcp_byte_t host_out_data_o,
    output logic       host_out_valid_o,
    output logic       host_out_last_o,
    input  logic       host_out_ready_i
);

    // Router to engine streams
    xfcp_byte_t [NUM_PORTS-1:0] dn_data;
    logic       [NUM_PORTS-1:0] dn_valid;
    logic       [NUM_PORTS-1:0] dn_last;
    logic       [NUM_PORTS-1:0] dn_ready;
    xfcp_byte_t [NUM_PORTS-1:0] up_data;
    logic       [NUM_PORTS-1:0] up_valid;
    logic       [NUM_PORTS-1:0] up_last;
    logic       [NUM_PORTS-1:0] up_ready;

    xfcp_router u_router (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .host_in_data_i   (host_in_data_i),
        .host_in_valid_i  (host_in_valid_i),
        .host_in_last_i   (host_in_last_i),
        .host_in_ready_o  (host_in_ready_o),
        .host_out_data_o  (host_out_data_o),
        .host_out_valid_o (host_out_valid_o),
        .host_out_last_o  (host_out_last_o),
        .host_out_ready_i (host_out_ready_i),
        .dn_data_o        (dn_data),
        .dn_valid_o       (dn_valid),
        .dn_last_o        (dn_last),
        .dn_ready_i       (dn_ready),
        .up_data_i        (up_data),
        .up_valid_i       (up_valid),
        .up_last_i        (up_last),
        .up_ready_o       (up_ready)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        wb_addr_t wb_adr;
        wb_word_t wb_dat_w;
        wb_word_t wb_dat_r;
        logic     wb_we;
        logic     wb_stb;
        logic     wb_cyc;
        logic     wb_ack;

        xfcp_wb_master u_master (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .dn_data_i  (dn_data[i]),
            .dn_valid_i (dn_valid[i]),
            .dn_last_i  (dn_last[i]),
            .dn_ready_o (dn_ready[i]),
            .up_data_o  (up_data[i]),
            .up_valid_o (up_valid[i]),
            .up_last_o  (up_last[i]),
            .up_ready_i (up_ready[i]),
            .wb_adr_o   (wb_adr),
            .wb_dat_o   (wb_dat_w),
            .wb_we_o    (wb_we),
            .wb_stb_o   (wb_stb),
            .wb_cyc_o   (wb_cyc),
            .wb_dat_i   (wb_dat_r),
            .wb_ack_i   (wb_ack)
        );

        wb_ram u_ram (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .adr_i   (wb_adr),
            .dat_i   (wb_dat_w),
            .we_i    (wb_we),
            .stb_i   (wb_stb),
            .cyc_i   (wb_cyc),
            .dat_o   (wb_dat_r),
            .ack_o   (wb_ack)
        );
    end

endmodule

// File: test/xfcp_core_checker.sv
/*
 * XFCP endpoint host stream checker
 * Concurrent assertions on the host response handshake, bound to the top
 */
`timescale 1ns/1ns

module xfcp_core_checker import xfcp_pkg::*; (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       in_ready_i,
    input xfcp_byte_t out_data_i,
    input logic       out_valid_i,
    input logic       out_last_i,
    input logic       out_ready_i
);

    int fail_count = 0;

    // Stalled response byte must hold
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=>
            out_valid_i && $stable(out_data_i) && $stable(out_last_i))
    else begin
        $error("host response byte changed while the host stalled");
        fail_count++;
    end

    a_out_reset: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
        $error("host response valid high during reset");
        fail_count++;
    end

    // No new request byte while a response is pending
    a_in_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> !in_ready_i)
    else begin
        $error("host request accepted while a response was pending");
        fail_count++;
    end

endmodule

// File: test/xfcp_core_tb.sv
/*
 * XFCP endpoint testbench
 * Sends read and write requests to all four ports, predicts each
 * response from a memory model and compares every response byte
 */
`timescale 1ns/1ns

module xfcp_core_tb import xfcp_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst_n_i;
    xfcp_byte_t host_in_data_i;
    logic       host_in_valid_i;
    logic       host_in_last_i;
    logic       host_in_ready_o;
    xfcp_byte_t host_out_data_o;
    logic       host_out_valid_o;
    logic       host_out_last_o;
    logic       host_out_ready_i;

    xfcp_byte_t  req_data[$];
    logic        req_last[$];
    xfcp_byte_t  exp_data[$];
    logic        exp_last[$];
    wb_word_t    model [NUM_PORTS][2**WB_ADDR_W];
    logic [31:0] rng = 32'd19;
    int          cycles = 0;
    int          limit = 0;

    xfcp_core dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n_i),
        .host_in_data_i   (host_in_data_i),
        .host_in_valid_i  (host_in_valid_i),
        .host_in_last_i   (host_in_last_i),
        .host_in_ready_o  (host_in_ready_o),
        .host_out_data_o  (host_out_data_o),
        .host_out_valid_o (host_out_valid_o),
        .host_out_last_o  (host_out_last_o),
        .host_out_ready_i (host_out_ready_i)
    );

    bind xfcp_core xfcp_core_checker u_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_ready_i  (host_in_ready_o),
        .out_data_i  (host_out_data_o),
        .out_valid_i (host_out_valid_o),
        .out_last_i  (host_out_last_o),
        .out_ready_i (host_out_ready_i)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input xfcp_byte_t got, input xfcp_byte_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("mismatch at %0t ns: %s got %h, expected %h",
                                       $time, name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("mismatch at %0t ns: %s got %b, expected %b",
                                       $time, name, got, exp));
        end
    endtask

    function automatic void expect_byte(input xfcp_byte_t data, input logic last);
        exp_data.push_back(data);
        exp_last.push_back(last);
    endfunction

    // Reference model updating the port memories and queuing the response
    function automatic void predict(input xfcp_byte_t pkt[$]);
        xfcp_byte_t port;
        xfcp_byte_t op;
        xfcp_byte_t addr;
        xfcp_byte_t n;
        wb_addr_t   a;
        wb_word_t   w;
        port = pkt[0];
        op   = pkt[1];
        addr = pkt[2];
        n    = pkt[3];
        if (int'(port) >= NUM_PORTS || (op != OP_READ_REQ && op != OP_WRITE_REQ)) begin
            return;
        end
        expect_byte(port, 1'b0);
        expect_byte(op + 8'd1, 1'b0);
        expect_byte(addr, 1'b0);
        expect_byte(n, op == OP_WRITE_REQ || n == 8'd0);
        for (int k = 0; k < int'(n); k++) begin
            // Word addresses wrap at 256
            a = addr + wb_addr_t'(k);
            if (op == OP_WRITE_REQ) begin
                w = {pkt[7 + 4*k], pkt[6 + 4*k], pkt[5 + 4*k], pkt[4 + 4*k]};
                model[port[1:0]][a] = w;
            end else begin
                w = model[port[1:0]][a];
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    expect_byte(w[8*b +: 8], k == int'(n) - 1 && b == BYTES_PER_WORD - 1);
                end
            end
        end
    endfunction

    function automatic void add_request(input xfcp_byte_t port, input xfcp_byte_t op,
                                        input xfcp_byte_t addr, input xfcp_byte_t n,
                                        input int data_words);
        xfcp_byte_t  pkt[$];
        logic [31:0] r;
        pkt.push_back(port);
        pkt.push_back(op);
        pkt.push_back(addr);
        pkt.push_back(n);
        for (int i = 0; i < BYTES_PER_WORD * data_words; i++) begin
            r = xorshift32();
            pkt.push_back(r[7:0]);
        end
        predict(pkt);
        foreach (pkt[i]) begin
            req_data.push_back(pkt[i]);
            req_last.push_back(i == pkt.size() - 1);
        end
    endfunction

    // Drives every queued request byte and waits for each to be taken
    task automatic send_requests();
        foreach (req_data[i]) begin
            host_in_data_i  <= req_data[i];
            host_in_valid_i <= 1'b1;
            host_in_last_i  <= req_last[i];
            @(posedge clk);
            while (!host_in_ready_o) begin
                @(posedge clk);
            end
        end
        host_in_valid_i <= 1'b0;
        host_in_last_i  <= 1'b0;
    endtask

    // Host ready about three cycles in four
    always @(posedge clk) begin
        host_out_ready_i <= (xorshift32() % 4) != 0;
    end

    always @(posedge clk) begin
        if (rst_n_i && host_out_valid_o && host_out_ready_i) begin
            if (exp_data.size() == 0) begin
                end_with_failure("unexpected response byte with no response pending");
            end else begin
                check_byte("host_out_data_o", host_out_data_o, exp_data.pop_front());
                check_last("host_out_last_o", host_out_last_o, exp_last.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            end_with_failure($sformatf("timeout after %0d cycles, %0d response bytes missing",
                                       cycles, exp_data.size()));
        end else if (dut.u_checker.fail_count != 0) begin
            end_with_failure("host stream assertion failed");
        end
    end

    initial begin
        rst_n_i          = 1'b0;
        host_in_data_i   = '0;
        host_in_valid_i  = 1'b0;
        host_in_last_i   = 1'b0;
        host_out_ready_i = 1'b0;

        // Same address on every port with different data
        for (int p = 0; p < NUM_PORTS; p++) begin
            add_request(xfcp_byte_t'(p), OP_WRITE_REQ, 8'h20, 8'd4, 4);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            add_request(xfcp_byte_t'(p), OP_READ_REQ, 8'h20, 8'd4, 0);
        end
        add_request(8'd2, OP_WRITE_REQ, 8'hfe, 8'd4, 4);
        add_request(8'd2, OP_READ_REQ, 8'hfe, 8'd4, 0);
        add_request(8'd2, OP_READ_REQ, 8'h00, 8'd2, 0);
        add_request(8'd1, OP_WRITE_REQ, 8'h05, 8'd0, 0);
        add_request(8'd3, OP_READ_REQ, 8'h09, 8'd0, 0);
        // Write data beyond N is dropped
        add_request(8'd0, OP_WRITE_REQ, 8'h40, 8'd1, 3);
        add_request(8'd0, OP_READ_REQ, 8'h40, 8'd1, 0);
        add_request(8'd7, OP_READ_REQ, 8'h20, 8'd1, 0);
        add_request(8'd1, 8'h20, 8'h20, 8'd1, 1);
        add_request(8'd1, OP_READ_REQ, 8'h20, 8'd4, 0);
        limit = 20 * req_data.size() + 40 * exp_data.size() + 200;

        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        send_requests();

        while (exp_data.size() != 0) begin
            @(posedge clk);
        end
        // Idle window to catch stray responses
        repeat (20) @(posedge clk);
        if (dut.u_checker.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            end_with_failure("host stream assertion failed");
        end
    end

endmodule

// File: build.f
verilog/xfcp_pkg.sv
verilog/wb_ram.sv
verilog/xfcp_wb_master.sv
verilog/xfcp_router.sv
verilog/xfcp_core.sv
test/xfcp_core_checker.sv
test/xfcp_core_tb.sv
